//--- common/model_pkg.sv
package model_pkg;

	// geometry of the on-chip model store
	// bits in one model byte
	localparam int BYTE_W = 8;

	// bytes packed into one memory word
	localparam int WORD_BYTES = 8;

	// full memory word
	localparam int WORD_W = WORD_BYTES * BYTE_W;

	// depth of the store in words
	localparam int MEM_WORDS = 1024;

	// word address width
	localparam int ADDR_W = $clog2(MEM_WORDS);

	// one byte of the incoming model stream
	typedef logic [BYTE_W-1:0] byte_t;

	// byte lane 0 holds the byte that arrived first
	typedef logic [WORD_W-1:0] word_t;

	// word address into the store
	typedef logic [ADDR_W-1:0] waddr_t;

endpackage

//--- common/bus_pkg.sv
package bus_pkg;

	// read address channel fields
	// only the burst length survives here
	// id, size, burst type and the rest are not carried

	// width of the burst length field
	// same width as the ar/aw len of the full bus
	localparam int LEN_W = 8;

	// beats in the burst minus one
	// a value of 0 means a single beat
	typedef logic [LEN_W-1:0] len_t;

endpackage

//--- loader/word_packer.sv
`timescale 1ns/1ps

module word_packer (
	input  logic               clk,
	input  logic               rst_n,

	// byte stream from the loader
	input  model_pkg::byte_t   byte_data,
	input  logic               byte_valid,
	output logic               byte_ready,
	input  logic               model_loaded,

	// packed word towards the app writer
	output model_pkg::word_t   word_data,
	output logic               word_valid,
	input  logic               word_taken
);

	localparam int CNT_W = $clog2(model_pkg::WORD_BYTES);

	// lane of the next byte within the word
	logic [CNT_W-1:0]  cnt;
	// assembly register
	// newest byte enters at the top lane and older ones move down
	model_pkg::word_t  shreg;
	model_pkg::word_t  packed_word;
	logic              byte_fire;
	logic              word_last;

	// holding stage frees up in the same cycle the writer takes it
	// no more bytes once the model is in memory
	assign byte_ready = !model_loaded && (!word_valid || word_taken);
	assign byte_fire = byte_valid && byte_ready;
	assign word_last = (cnt == CNT_W'(model_pkg::WORD_BYTES - 1));
	// word as it looks after this byte is shifted in
	assign packed_word = {byte_data, shreg[model_pkg::WORD_W-1:model_pkg::BYTE_W]};

	// byte counter and holding stage flag
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
			word_valid <= 1'b0;
		end else begin
			if (byte_fire) begin
				cnt <= word_last ? '0 : cnt + 1'b1;
			end
			// a new full word beats a take in the same cycle
			if (byte_fire && word_last) begin
				word_valid <= 1'b1;
			end else if (word_taken) begin
				word_valid <= 1'b0;
			end
		end
	end

	// payload path
	always_ff @(posedge clk) begin
		if (byte_fire) begin
			shreg <= packed_word;
		end
		// eighth byte completes the word
		if (byte_fire && word_last) begin
			word_data <= packed_word;
		end
	end

endmodule

//--- loader/app_writer.sv
`timescale 1ns/1ps

module app_writer #(
	parameter int MODEL_WORDS = 32
) (
	input  logic               clk,
	input  logic               rst_n,

	// held word from the packer
	input  model_pkg::word_t   word_data,
	input  logic               word_valid,
	output logic               word_taken,

	// app write port of the memory
	input  logic               app_rdy,
	output logic               app_cmd_en,
	output model_pkg::waddr_t  app_addr,
	output model_pkg::word_t   app_wdf_data,

	// level once the whole model sits in memory
	output logic               model_loaded
);

	typedef enum logic {
		WR_LOADING,
		WR_LOADED
	} writer_state_t;

	writer_state_t      state;
	// address of the next write
	// doubles as the count of words already written
	model_pkg::waddr_t  wr_addr;
	logic               last_word;

	// one write per held word, only while the memory accepts
	assign app_cmd_en = word_valid && app_rdy && (state == WR_LOADING);
	// the word leaves the holding stage with its write
	assign word_taken = app_cmd_en;
	assign app_addr = wr_addr;
	assign app_wdf_data = word_data;
	assign model_loaded = (state == WR_LOADED);
	assign last_word = (wr_addr == model_pkg::waddr_t'(MODEL_WORDS - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= WR_LOADING;
			wr_addr <= '0;
		end else begin
			case (state)
				WR_LOADING: begin
					if (app_cmd_en) begin
						wr_addr <= wr_addr + 1'b1;
						// final word written, loaded from next cycle on
						if (last_word) begin
							state <= WR_LOADED;
						end
					end
				end
				WR_LOADED: begin
					// stays here until reset
					state <= WR_LOADED;
				end
				default: begin
					state <= WR_LOADING;
				end
			endcase
		end
	end

endmodule

//--- hdl/model_mem.sv
`timescale 1ns/1ps

module model_mem (
	input  logic               clk,
	input  logic               rst_n,

	// app write port
	input  logic               app_cmd_en,
	input  model_pkg::waddr_t  app_addr,
	input  model_pkg::word_t   app_wdf_data,
	output logic               app_rdy,

	// read address channel
	input  model_pkg::waddr_t  araddr,
	input  bus_pkg::len_t      arlen,
	input  logic               arvalid,
	output logic               arready,

	// read data channel
	output model_pkg::word_t   rdata,
	output logic               rvalid,
	output logic               rlast,
	input  logic               rready
);

	// word store standing in for the ddr
	model_pkg::word_t   mem [model_pkg::MEM_WORDS];

	// burst engine state
	logic               busy;
	// address of the beat after the one on the bus
	model_pkg::waddr_t  next_addr;
	// beats still to come after the current one
	bus_pkg::len_t      beats_left;
	model_pkg::waddr_t  rd_addr;
	logic               ar_fire;
	logic               r_fire;
	logic               rd_en;

	// idle engine takes both new bursts and app writes
	assign arready = !busy;
	assign app_rdy = !busy;
	// a beat is on the bus for the whole burst
	assign rvalid = busy;
	assign ar_fire = arvalid && arready;
	assign r_fire = rvalid && rready;

	// fetch on accept and after every moved beat but the last
	assign rd_en = ar_fire || (r_fire && !rlast);
	// ar accept and beat moves never meet, busy keeps them apart
	assign rd_addr = ar_fire ? araddr : next_addr;

	// single write port and single read port
	always_ff @(posedge clk) begin
		if (app_cmd_en && app_rdy) begin
			mem[app_addr] <= app_wdf_data;
		end
		// rdata holds while rready is low
		if (rd_en) begin
			rdata <= mem[rd_addr];
		end
	end

	// burst framing
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			rlast <= 1'b0;
		end else if (ar_fire) begin
			busy <= 1'b1;
			// single beat burst is last right away
			rlast <= (arlen == '0);
		end else if (r_fire) begin
			if (rlast) begin
				busy <= 1'b0;
				rlast <= 1'b0;
			end else begin
				rlast <= (beats_left == bus_pkg::len_t'(1));
			end
		end
	end

	// burst address and beat count
	always_ff @(posedge clk) begin
		if (ar_fire) begin
			next_addr <= araddr + 1'b1;
			beats_left <= arlen;
		end else if (rd_en) begin
			next_addr <= next_addr + 1'b1;
			beats_left <= beats_left - 1'b1;
		end
	end

endmodule

//--- hdl/read_sweeper.sv
`timescale 1ns/1ps

module read_sweeper #(
	parameter int MODEL_WORDS = 32,
	parameter int BURST_LEN   = 8
) (
	input  logic               clk,
	input  logic               rst_n,

	// start condition
	input  logic               model_loaded,

	// read address channel
	output model_pkg::waddr_t  araddr,
	output bus_pkg::len_t      arlen,
	output logic               arvalid,
	input  logic               arready,

	// read data handshake, watched for the end of each burst
	input  logic               rvalid,
	input  logic               rready,
	input  logic               rlast,

	output logic               sweep_done
);

	typedef enum logic [1:0] {
		SW_WAIT,
		SW_REQUEST,
		SW_BURST,
		SW_DONE
	} sweep_state_t;

	sweep_state_t       state;
	// start address of the current burst
	model_pkg::waddr_t  base;
	logic               last_burst;
	logic               burst_end;

	assign araddr = base;
	// fixed length for every burst
	assign arlen = bus_pkg::len_t'(BURST_LEN - 1);
	// address held steady while waiting for arready
	assign arvalid = (state == SW_REQUEST);
	assign sweep_done = (state == SW_DONE);
	// last beat of the burst actually moved
	assign burst_end = rvalid && rready && rlast;
	assign last_burst = (base == model_pkg::waddr_t'(MODEL_WORDS - BURST_LEN));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= SW_WAIT;
			base <= '0;
		end else begin
			case (state)
				// nothing to read before the model is in
				SW_WAIT: begin
					if (model_loaded) begin
						state <= SW_REQUEST;
					end
				end
				SW_REQUEST: begin
					if (arready) begin
						state <= SW_BURST;
					end
				end
				SW_BURST: begin
					if (burst_end) begin
						if (last_burst) begin
							state <= SW_DONE;
						end else begin
							// next burst starts right after this one
							base <= base + model_pkg::waddr_t'(BURST_LEN);
							state <= SW_REQUEST;
						end
					end
				end
				SW_DONE: begin
					state <= SW_DONE;
				end
				default: begin
					state <= SW_WAIT;
				end
			endcase
		end
	end

endmodule

//--- hdl/model_top.sv
`timescale 1ns/1ps

module model_top #(
	parameter int MODEL_WORDS = 32,
	parameter int BURST_LEN   = 8
) (
	input  logic               clk,
	input  logic               rst_n,

	// model byte stream
	input  model_pkg::byte_t   byte_data,
	input  logic               byte_valid,
	output logic               byte_ready,

	// read beats of the sweep
	input  logic               rready,
	output model_pkg::word_t   rdata,
	output logic               rvalid,
	output logic               rlast,

	// status levels, model_loaded is the led bit
	output logic               model_loaded,
	output logic               sweep_done
);

	// packer to writer
	model_pkg::word_t   word_data;
	logic               word_valid;
	logic               word_taken;

	// app write port
	logic               app_cmd_en;
	model_pkg::waddr_t  app_addr;
	model_pkg::word_t   app_wdf_data;
	logic               app_rdy;

	// read address channel
	model_pkg::waddr_t  araddr;
	bus_pkg::len_t      arlen;
	logic               arvalid;
	logic               arready;

	word_packer packer (
		.clk			(clk			),
		.rst_n			(rst_n			),
		.byte_data		(byte_data		),
		.byte_valid		(byte_valid		),
		.byte_ready		(byte_ready		),
		.model_loaded	(model_loaded	),
		.word_data		(word_data		),
		.word_valid		(word_valid		),
		.word_taken		(word_taken		)
	);

	app_writer #(
		.MODEL_WORDS	(MODEL_WORDS	)
	) writer (
		.clk			(clk			),
		.rst_n			(rst_n			),
		.word_data		(word_data		),
		.word_valid		(word_valid		),
		.word_taken		(word_taken		),
		.app_rdy		(app_rdy		),
		.app_cmd_en		(app_cmd_en		),
		.app_addr		(app_addr		),
		.app_wdf_data	(app_wdf_data	),
		.model_loaded	(model_loaded	)
	);

	model_mem mem (
		.clk			(clk			),
		.rst_n			(rst_n			),
		.app_cmd_en		(app_cmd_en		),
		.app_addr		(app_addr		),
		.app_wdf_data	(app_wdf_data	),
		.app_rdy		(app_rdy		),
		.araddr			(araddr			),
		.arlen			(arlen			),
		.arvalid		(arvalid		),
		.arready		(arready		),
		.rdata			(rdata			),
		.rvalid			(rvalid			),
		.rlast			(rlast			),
		.rready			(rready			)
	);

	// read test generator, waits for the loaded level
	read_sweeper #(
		.MODEL_WORDS	(MODEL_WORDS	),
		.BURST_LEN		(BURST_LEN		)
	) sweeper (
		.clk			(clk			),
		.rst_n			(rst_n			),
		.model_loaded	(model_loaded	),
		.araddr			(araddr			),
		.arlen			(arlen			),
		.arvalid		(arvalid		),
		.arready		(arready		),
		.rvalid			(rvalid			),
		.rready			(rready			),
		.rlast			(rlast			),
		.sweep_done		(sweep_done		)
	);

endmodule

//--- tb/model_top_sva.sv
`timescale 1ns/1ps

module model_top_sva (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               arvalid,
	input  logic               arready,
	input  model_pkg::waddr_t  araddr,
	input  bus_pkg::len_t      arlen,
	input  model_pkg::word_t   rdata,
	input  logic               rvalid,
	input  logic               rready,
	input  logic               app_cmd_en,
	input  logic               app_rdy,
	input  logic               model_loaded
);

	// request held with a steady address until the memory takes it
	assert property (@(posedge clk) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
		else $error("arvalid dropped or address changed before arready");

	// stalled beat keeps its data
	assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else $error("read beat changed while rready was low");

	// no write while the memory serves a burst
	assert property (@(posedge clk) disable iff (!rst_n)
		!app_rdy |-> !app_cmd_en)
		else $error("app write issued while app_rdy was low");

	// reads only of a complete model
	assert property (@(posedge clk) disable iff (!rst_n)
		rvalid |-> model_loaded)
		else $error("read beat seen before the model was loaded");

endmodule

bind model_top model_top_sva sva (
	.clk			(clk			),
	.rst_n			(rst_n			),
	.arvalid		(arvalid		),
	.arready		(arready		),
	.araddr			(araddr			),
	.arlen			(arlen			),
	.rdata			(rdata			),
	.rvalid			(rvalid			),
	.rready			(rready			),
	.app_cmd_en		(app_cmd_en		),
	.app_rdy		(app_rdy		),
	.model_loaded	(model_loaded	)
);

//--- tb/tb_model_top.sv
`timescale 1ns/1ps

module tb_model_top;

	localparam int MODEL_WORDS = 32;
	localparam int BURST_LEN = 8;
	localparam int WORD_BYTES = model_pkg::WORD_BYTES;
	localparam int TOTAL_BYTES = MODEL_WORDS * WORD_BYTES;
	localparam int CLK_PERIOD = 4;
	localparam int NUM_TESTS = 6;
	// cycles per row
	// load and sweep at a quarter byte rate plus slack
	localparam int ROW_CYCLES = MODEL_WORDS * WORD_BYTES * 4 + 200;

	// byte pattern kinds
	localparam int PAT_INC = 0;
	localparam int PAT_ONES = 1;
	localparam int PAT_RAND = 2;

	// test table
	string test_name [NUM_TESTS] = '{"inc_clean", "ones_clean", "rand_gaps",
		"rand_stalls", "inc_gaps_stalls", "rand_heavy"};
	int test_kind [NUM_TESTS] = '{PAT_INC, PAT_ONES, PAT_RAND, PAT_RAND, PAT_INC, PAT_RAND};
	int gap_pct [NUM_TESTS] = '{0, 0, 30, 0, 25, 50};
	int stall_pct [NUM_TESTS] = '{0, 0, 0, 40, 50, 60};

	logic               clk = 1'b0;
	logic               rst_n;
	model_pkg::byte_t   byte_data;
	logic               byte_valid;
	logic               byte_ready;
	logic               rready;
	model_pkg::word_t   rdata;
	logic               rvalid;
	logic               rlast;
	logic               model_loaded;
	logic               sweep_done;

	int                 seed = 32'h1bf7_fdf2;
	int                 errors = 0;
	int                 row_errors;
	int                 failed_tests = 0;
	string              cur_name;
	model_pkg::byte_t   sent_bytes [TOTAL_BYTES];
	model_pkg::word_t   exp_words [MODEL_WORDS];

	model_top #(
		.MODEL_WORDS	(MODEL_WORDS	),
		.BURST_LEN		(BURST_LEN		)
	) DUT (
		.clk			(clk			),
		.rst_n			(rst_n			),
		.byte_data		(byte_data		),
		.byte_valid		(byte_valid		),
		.byte_ready		(byte_ready		),
		.rready			(rready			),
		.rdata			(rdata			),
		.rvalid			(rvalid			),
		.rlast			(rlast			),
		.model_loaded	(model_loaded	),
		.sweep_done		(sweep_done		)
	);

	initial begin
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// watchdog over all rows
	initial begin
		#(NUM_TESTS * ROW_CYCLES * CLK_PERIOD);
		$display("timeout: the sweep did not finish in %0d cycles", NUM_TESTS * ROW_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	// true with the given chance in percent
	function automatic logic chance(input int pct);
		int r;
		r = $random(seed) & 32'h7fff_ffff;
		return (r % 100) < pct;
	endfunction

	task automatic check_value(input string what, input model_pkg::word_t expected,
		input model_pkg::word_t actual);
		assert (actual === expected) else begin
			$display("ERROR %s: %s expected %h actual %h", cur_name, what, expected, actual);
			errors++;
			row_errors++;
		end
	endtask

	task automatic check_cond(input logic cond, input string what);
		assert (cond === 1'b1) else begin
			$display("ERROR %s: %s", cur_name, what);
			errors++;
			row_errors++;
		end
	endtask

	// byte stream and the words it packs into
	// first byte lands in lane 0
	task automatic build_stream(input int kind);
		for (int i = 0; i < TOTAL_BYTES; i++) begin
			case (kind)
				PAT_INC: sent_bytes[i] = model_pkg::byte_t'(i);
				PAT_ONES: sent_bytes[i] = 8'hff;
				default: sent_bytes[i] = model_pkg::byte_t'($random(seed));
			endcase
		end
		for (int w = 0; w < MODEL_WORDS; w++) begin
			for (int b = 0; b < WORD_BYTES; b++) begin
				exp_words[w][8*b +: 8] = sent_bytes[w * WORD_BYTES + b];
			end
		end
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		byte_valid = 1'b0;
		byte_data = '0;
		rready = 1'b0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		check_cond(!model_loaded && !sweep_done, "status levels high after reset");
		check_cond(!rvalid && !rlast, "read channel active after reset");
		check_cond(byte_ready, "byte_ready low after reset");
	endtask

	task automatic run_test(input int row);
		int accepted;
		int beats;
		logic seen_loaded;
		logic finished;
		accepted = 0;
		beats = 0;
		seen_loaded = 1'b0;
		finished = 1'b0;
		row_errors = 0;
		cur_name = test_name[row];
		build_stream(test_kind[row]);
		apply_reset();
		while (!finished) begin
			// load completion against bytes taken so far
			if (seen_loaded) begin
				check_cond(model_loaded, "model_loaded fell after rising");
			end
			if (model_loaded) begin
				seen_loaded = 1'b1;
				check_cond(accepted == TOTAL_BYTES, "model_loaded high before all bytes taken");
				check_cond(!byte_ready, "byte_ready high after model_loaded");
			end
			// next byte
			// dut outputs stay put until the rising edge
			if (accepted < TOTAL_BYTES && !chance(gap_pct[row])) begin
				byte_valid = 1'b1;
				byte_data = sent_bytes[accepted];
			end else begin
				byte_valid = 1'b0;
			end
			if (byte_valid && byte_ready) begin
				accepted++;
			end
			rready = !chance(stall_pct[row]);
			// beat that moves at the coming edge
			if (rvalid && rready) begin
				if (beats < MODEL_WORDS) begin
					check_value($sformatf("rdata of beat %0d", beats), exp_words[beats], rdata);
					check_value($sformatf("rlast of beat %0d", beats),
						model_pkg::word_t'((beats + 1) % BURST_LEN == 0),
						model_pkg::word_t'(rlast));
				end else begin
					check_cond(1'b0, "read beat after the whole model was swept");
				end
				beats++;
			end
			if (sweep_done) begin
				check_value("beat count at sweep_done", model_pkg::word_t'(MODEL_WORDS),
					model_pkg::word_t'(beats));
				finished = 1'b1;
			end else begin
				@(negedge clk);
			end
		end
		if (row_errors == 0) begin
			$display("test %s: ok", cur_name);
		end else begin
			$display("test %s: %0d errors", cur_name, row_errors);
			failed_tests++;
		end
	endtask

	initial begin
		rst_n = 1'b0;
		byte_data = '0;
		byte_valid = 1'b0;
		rready = 1'b0;
		for (int row = 0; row < NUM_TESTS; row++) begin
			run_test(row);
		end
		$display("tests %0d, failed %0d, errors %0d", NUM_TESTS, failed_tests, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- filelist.f
common/model_pkg.sv
common/bus_pkg.sv
loader/word_packer.sv
loader/app_writer.sv
hdl/model_mem.sv
hdl/read_sweeper.sv
hdl/model_top.sv
tb/model_top_sva.sv
tb/tb_model_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the model_top testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	--top-module tb_model_top \
	-f filelist.f \
	-o sim_model_top

# keep going to the log check even if the simulator exits nonzero
./obj_dir/sim_model_top | tee sim.log || true

if grep -q "Simulation completed successfully" sim.log; then
	echo "run.sh: testbench passed"
	exit 0
else
	echo "run.sh: testbench failed, see sim.log"
	exit 1
fi
